// ==== compile.f ====
pq_pkg.sv
pq_cmd_capture.sv
pq_sequencer.sv
pq_value_router.sv
pq_bram.sv
pq_result_out.sv
pq_top.sv
pq_chk.sv
pq_tb.sv

// ==== Bender.yml ====
package:
  name: pq

sources:
  - files:
      - pq_pkg.sv
      - pq_cmd_capture.sv
      - pq_sequencer.sv
      - pq_value_router.sv
      - pq_bram.sv
      - pq_result_out.sv
      - pq_top.sv
  - target: test
    files:
      - pq_chk.sv
      - pq_tb.sv

// ==== pq_tb.sv ====
module pq_tb;
   import pq_pkg::*;

   ////////////////////
   // Limits
   ////////////////////

   // Longest single operation, a full insert walk plus capture and finish
   localparam int MAX_OP_CYC  = 2 * DEPTH + 6;
   // Strobe to busy rise
   localparam int START_CYC   = 4;
   // About 200 operations of MAX_OP_CYC each, rounded up for margin
   localparam int TIMEOUT_CYC = 10000;
   localparam int RAND_OPS    = 150;
   localparam logic [31:0] SEED = 32'h4666_ff86;

   logic              clk;
   logic              rst;
   logic              enq;
   logic              deq;
   logic [DATA_W-1:0] enq_data;
   logic              busy;
   logic              deq_valid;
   logic [DATA_W-1:0] deq_data;
   logic              err;
   pq_status_t        status;

   // Reference model, descending, head at index 0
   logic [DATA_W-1:0] model[$];

   int    cycle_cnt = 0;
   int    error_cnt;
   int    check_cnt;
   int    test_cnt;
   int    test_fail_cnt;
   int    test_err_base;
   string cur_test;

   // Results of the last operation
   logic              res_valid;
   logic              res_err;
   logic [DATA_W-1:0] res_data;

   pq_top pq_top_inst (
      .clk      (clk),
      .rst      (rst),
      .enq      (enq),
      .deq      (deq),
      .enq_data (enq_data),
      .busy     (busy),
      .deq_valid(deq_valid),
      .deq_data (deq_data),
      .err      (err),
      .status   (status)
   );

   always #5 clk = ~clk;

   // Run limit
   always @(posedge clk) begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt >= TIMEOUT_CYC) begin
         $display("Timeout: run stopped after %0d cycles without finishing", cycle_cnt);
         $display("*** FAILED ***");
         $finish;
      end
   end

   ////////////////////
   // Helpers
   ////////////////////

   // Inputs change 1 unit after the edge, outputs read there too
   task automatic step();
      @(posedge clk);
      #1;
   endtask

   task automatic check_val(input string what, input logic [DATA_W-1:0] exp,
                            input logic [DATA_W-1:0] act);
      check_cnt++;
      if (exp !== act) begin
         error_cnt++;
         $display("** Error %s %s: expected %h, actual %h", cur_test, what, exp, act);
      end
   endtask

   task automatic note_failure(input string msg);
      error_cnt++;
      $display("%s: %s", cur_test, msg);
   endtask

   // Strict compare, equal keys go behind their copies
   function automatic void model_insert(input logic [DATA_W-1:0] key);
      int pos;
      pos = model.size();
      for (int i = 0; i < model.size(); i++) begin
         if (key > model[i]) begin
            pos = i;
            break;
         end
      end
      model.insert(pos, key);
   endfunction

   task automatic check_status();
      check_val("count", model.size(), status.count);
      check_val("full", model.size() == DEPTH, status.full);
      check_val("empty", model.size() == 0, status.empty);
   endtask

   // One-cycle strobe
   task automatic issue(input logic is_enq, input logic [DATA_W-1:0] key);
      enq      = is_enq;
      deq      = ~is_enq;
      enq_data = key;
      step();
      enq = 1'b0;
      deq = 1'b0;
   endtask

   task automatic wait_busy_rise(output logic ok);
      int n;
      n = 0;
      while (!busy && n < START_CYC) begin
         step();
         n++;
      end
      ok = busy;
      if (!ok) begin
         note_failure("command was not accepted, busy never went high");
      end
   endtask

   task automatic wait_busy_fall(output logic ok);
      int n;
      n = 0;
      while (busy && n < MAX_OP_CYC) begin
         step();
         n++;
      end
      ok = !busy;
      if (!ok) begin
         note_failure("operation did not finish, busy stuck high");
      end
   endtask

   // Results land in the first cycle with busy low
   task automatic do_op(input logic is_enq, input logic [DATA_W-1:0] key);
      logic ok;
      res_valid = 1'b0;
      res_err   = 1'b0;
      res_data  = '0;
      issue(is_enq, key);
      wait_busy_rise(ok);
      if (ok) begin
         wait_busy_fall(ok);
      end
      if (ok) begin
         res_valid = deq_valid;
         res_err   = err;
         res_data  = deq_data;
         step();
         // Pulses last one cycle only
         check_val("pulse width", 2'b00, {deq_valid, err});
      end
   endtask

   task automatic enq_check(input logic [DATA_W-1:0] key);
      logic exp_err;
      exp_err = (model.size() == DEPTH);
      do_op(1'b1, key);
      if (!exp_err) begin
         model_insert(key);
      end
      check_val("insert err", exp_err, res_err);
      check_val("insert deq_valid", 1'b0, res_valid);
      check_status();
   endtask

   task automatic deq_check(output logic [DATA_W-1:0] got);
      logic              exp_err;
      logic [DATA_W-1:0] exp_key;
      exp_err = (model.size() == 0);
      exp_key = '0;
      if (!exp_err) begin
         exp_key = model.pop_front();
      end
      do_op(1'b0, '0);
      check_val("dequeue err", exp_err, res_err);
      check_val("deq_valid", !exp_err, res_valid);
      if (!exp_err) begin
         check_val("deq_data", exp_key, res_data);
      end
      got = res_data;
      check_status();
   endtask

   // Drains the queue, each key no larger than the one before
   task automatic drain_sorted();
      logic [DATA_W-1:0] got;
      logic [DATA_W-1:0] prev;
      int                n;
      n = model.size();
      for (int i = 0; i < n; i++) begin
         deq_check(got);
         if (i > 0) begin
            check_val("non-increasing order", 1'b1, got <= prev);
         end
         prev = got;
      end
   endtask

   task automatic start_test(input string name);
      cur_test      = name;
      test_err_base = error_cnt;
   endtask

   task automatic end_test();
      int errs;
      errs = error_cnt - test_err_base;
      test_cnt++;
      if (errs != 0) begin
         test_fail_cnt++;
      end
      $display("Test %-12s %s, %0d errors", cur_test, (errs == 0) ? "ok" : "bad", errs);
   endtask

   ////////////////////
   // Tests
   ////////////////////

   task automatic test_reset();
      logic [DATA_W-1:0] got;
      start_test("reset");
      check_val("busy", 1'b0, busy);
      check_status();
      // Empty queue rejects a dequeue
      deq_check(got);
      end_test();
   endtask

   task automatic test_sorted();
      logic [DATA_W-1:0] keys [8] = '{32'h10, 32'h3, 32'h80, 32'h7,
                                      32'h55, 32'h1, 32'hA0, 32'h20};
      start_test("sorted");
      foreach (keys[i]) begin
         enq_check(keys[i]);
      end
      drain_sorted();
      end_test();
   endtask

   task automatic test_full();
      start_test("full");
      for (int i = 0; i < DEPTH; i++) begin
         enq_check((i * 32'h9E37_79B9) ^ 32'h5A5A_0000);
      end
      check_val("full after 16", 1'b1, status.full);
      // 17th insert, model stays as it is
      enq_check(32'hFFFF_0000);
      drain_sorted();
      end_test();
   endtask

   task automatic test_extremes();
      logic [DATA_W-1:0] keys [10] = '{32'h0, 32'hFFFF_FFFF, 32'h5, 32'h5, 32'h0,
                                       32'hFFFF_FFFF, 32'h7, 32'h5, 32'h1, 32'h0};
      start_test("extremes");
      foreach (keys[i]) begin
         enq_check(keys[i]);
      end
      drain_sorted();
      end_test();
   endtask

   task automatic test_busy_drop();
      logic ok;
      start_test("busy_drop");
      for (int i = 0; i < 4; i++) begin
         enq_check(32'h100 + i * 32'h33);
      end
      issue(1'b1, 32'h0000_0042);
      wait_busy_rise(ok);
      if (ok) begin
         // Strobe held through the whole walk, last busy cycle included
         enq      = 1'b1;
         enq_data = 32'hDEAD_BEEF;
         wait_busy_fall(ok);
         enq = 1'b0;
         step();
      end
      model_insert(32'h0000_0042);
      check_status();
      repeat (3) step();
      check_val("idle after drop", 1'b0, busy);
      check_status();
      drain_sorted();
      end_test();
   endtask

   task automatic test_random();
      logic [DATA_W-1:0] key;
      logic [DATA_W-1:0] got;
      start_test("random");
      for (int i = 0; i < RAND_OPS; i++) begin
         if ($urandom_range(99) < 55) begin
            // Small keys now and then, to force duplicates
            if ($urandom_range(3) == 0) begin
               key = $urandom_range(7);
            end else begin
               key = $urandom;
            end
            enq_check(key);
         end else begin
            deq_check(got);
         end
      end
      drain_sorted();
      end_test();
   endtask

   ////////////////////
   // Main
   ////////////////////

   initial begin
      void'($urandom(SEED));
      clk           = 1'b0;
      rst           = 1'b1;
      enq           = 1'b0;
      deq           = 1'b0;
      enq_data      = '0;
      error_cnt     = 0;
      check_cnt     = 0;
      test_cnt      = 0;
      test_fail_cnt = 0;
      repeat (5) @(posedge clk);
      #1;
      rst = 1'b0;
      step();

      test_reset();
      test_sorted();
      test_full();
      test_extremes();
      test_busy_drop();
      test_random();

      $display("Summary: %0d tests, %0d with errors, %0d checks, %0d errors",
               test_cnt, test_fail_cnt, check_cnt, error_cnt);
      if (error_cnt == 0) begin
         $display("*** PASSED ***");
      end else begin
         $display("*** FAILED ***");
      end
      $finish;
   end

endmodule

// ==== pq_chk.sv ====
module pq_chk (
   input logic               clk,
   input logic               rst,
   input logic               busy,
   input logic               deq_valid,
   input logic               err,
   input pq_pkg::pq_status_t status
);
   import pq_pkg::*;

   ////////////////////
   // Status
   ////////////////////

   // Count 0 means empty, DEPTH means full, never both
   a_full_empty : assert property (@(posedge clk) disable iff (rst)
      !(status.full && status.empty))
      else $error("full and empty high together");

   a_count_range : assert property (@(posedge clk) disable iff (rst)
      status.count <= CNT_W'(DEPTH))
      else $error("occupancy count above capacity");

   ////////////////////
   // Pulses
   ////////////////////

   // An operation ends either way, not both
   a_valid_err : assert property (@(posedge clk) disable iff (rst)
      !(deq_valid && err))
      else $error("deq_valid and err high together");

   // Result shows up with the falling edge of busy
   a_valid_end : assert property (@(posedge clk) disable iff (rst)
      deq_valid |-> $fell(busy))
      else $error("deq_valid without busy falling");

endmodule

bind pq_top pq_chk pq_chk_inst (
   .clk      (clk),
   .rst      (rst),
   .busy     (busy),
   .deq_valid(deq_valid),
   .err      (err),
   .status   (status)
);

// ==== pq_top.sv ====
module pq_top (
   input  logic                      clk,
   input  logic                      rst,
   input  logic                      enq,
   input  logic                      deq,
   input  logic [pq_pkg::DATA_W-1:0] enq_data,
   output logic                      busy,
   output logic                      deq_valid,
   output logic [pq_pkg::DATA_W-1:0] deq_data,
   output logic                      err,
   output pq_pkg::pq_status_t        status
);
   import pq_pkg::*;

   // Input side to sequencer
   logic              cmd_valid;
   pq_cmd_t           cmd;
   // Sequencer to BRAM
   logic [ADDR_W-1:0] addr;
   logic              we;
   logic [DATA_W-1:0] wdata;
   logic [DATA_W-1:0] rdata;
   // Sequencer and router
   route_req_t        req;
   route_rsp_t        rsp;
   // Sequencer to output side
   logic              op_done;
   logic              op_err;
   logic [DATA_W-1:0] head_key;

   ////////////////////
   // Input side
   ////////////////////

   pq_cmd_capture pq_cmd_capture_inst (
      .clk       (clk),
      .rst       (rst),
      .enq       (enq),
      .deq       (deq),
      .enq_data  (enq_data),
      .busy      (busy),
      .cmd_valid (cmd_valid),
      .cmd       (cmd)
   );

   ////////////////////
   // Processing
   ////////////////////

   pq_sequencer pq_sequencer_inst (
      .clk       (clk),
      .rst       (rst),
      .cmd_valid (cmd_valid),
      .cmd       (cmd),
      .busy      (busy),
      .addr      (addr),
      .we        (we),
      .wdata     (wdata),
      .rdata     (rdata),
      .req       (req),
      .rsp       (rsp),
      .status    (status),
      .op_done   (op_done),
      .op_err    (op_err),
      .head_key  (head_key)
   );

   pq_value_router pq_value_router_inst (
      .req (req),
      .rsp (rsp)
   );

   pq_bram pq_bram_inst (
      .clk   (clk),
      .addr  (addr),
      .we    (we),
      .wdata (wdata),
      .rdata (rdata)
   );

   ////////////////////
   // Output side
   ////////////////////

   // Command register holds its payload for the whole operation
   pq_result_out pq_result_out_inst (
      .clk       (clk),
      .rst       (rst),
      .op_done   (op_done),
      .op_err    (op_err),
      .head_key  (head_key),
      .op_is_deq (cmd.op_deq),
      .deq_valid (deq_valid),
      .deq_data  (deq_data),
      .err       (err)
   );

endmodule

// ==== pq_result_out.sv ====
module pq_result_out (
   input  logic                      clk,
   input  logic                      rst,
   input  logic                      op_done,
   input  logic                      op_err,
   input  logic [pq_pkg::DATA_W-1:0] head_key,
   input  logic                      op_is_deq,
   output logic                      deq_valid,
   output logic [pq_pkg::DATA_W-1:0] deq_data,
   output logic                      err
);

   ////////////////////
   // Result pulses
   ////////////////////

   // Dequeue finished this cycle
   logic deq_fin;

   assign deq_fin = op_done & op_is_deq;

   // One-cycle pulses, one cycle after the sequencer
   // Lands in the first cycle with busy low
   always_ff @(posedge clk) begin
      if (rst) begin
         deq_valid <= 1'b0;
         err       <= 1'b0;
      end else begin
         deq_valid <= deq_fin;
         // Rejected insert or dequeue
         err       <= op_err;
      end
   end

   ////////////////////
   // Result data
   ////////////////////

   // Held until the next dequeue completes
   always_ff @(posedge clk) begin
      if (deq_fin) begin
         deq_data <= head_key;
      end
   end

endmodule

// ==== pq_bram.sv ====
module pq_bram (
   input  logic                      clk,
   input  logic [pq_pkg::ADDR_W-1:0] addr,
   input  logic                      we,
   input  logic [pq_pkg::DATA_W-1:0] wdata,
   output logic [pq_pkg::DATA_W-1:0] rdata
);
   import pq_pkg::*;

   ////////////////////
   // Storage
   ////////////////////

   // Sorted keys, largest at address 0
   // Only addresses below the count hold valid keys
   logic [DATA_W-1:0] mem [DEPTH];

   // Single port, read-first
   // Read data valid one cycle after the address
   always_ff @(posedge clk) begin
      if (we) begin
         mem[addr] <= wdata;
      end
      rdata <= mem[addr];
   end

endmodule

// ==== pq_value_router.sv ====
module pq_value_router (
   input  pq_pkg::route_req_t req,
   output pq_pkg::route_rsp_t rsp
);
   import pq_pkg::*;

   ////////////////////
   // Compare
   ////////////////////

   // Carried key wins the slot
   // Strict compare, so equal keys queue behind existing copies
   // Tail slot holds no valid key and is always taken
   logic take;

   assign take = req.at_tail || (req.carried > req.bram_key);

   ////////////////////
   // Route
   ////////////////////

   always_comb begin
      rsp = '0;
      case (req.mode)
         ROUTE_SWAP: begin
            if (take) begin
               // Carried key goes in, stored key travels on
               rsp.bram_insert = req.carried;
               rsp.to_register = req.bram_key;
               rsp.swapped     = 1'b1;
            end else begin
               // Stored key stays put
               rsp.bram_insert = req.bram_key;
               rsp.to_register = req.carried;
               rsp.swapped     = 1'b0;
            end
         end
         ROUTE_SHIFT: begin
            // Key read from the next address moves down one
            rsp.bram_insert = req.bram_key;
            // Carried key untouched during a dequeue
            rsp.to_register = req.carried;
            rsp.swapped     = 1'b0;
         end
         default: begin
            // Idle, all zero
            rsp = '0;
         end
      endcase
   end

endmodule

// ==== pq_sequencer.sv ====
module pq_sequencer (
   input  logic                      clk,
   input  logic                      rst,
   input  logic                      cmd_valid,
   input  pq_pkg::pq_cmd_t           cmd,
   output logic                      busy,
   output logic [pq_pkg::ADDR_W-1:0] addr,
   output logic                      we,
   output logic [pq_pkg::DATA_W-1:0] wdata,
   input  logic [pq_pkg::DATA_W-1:0] rdata,
   output pq_pkg::route_req_t        req,
   input  pq_pkg::route_rsp_t        rsp,
   output pq_pkg::pq_status_t        status,
   output logic                      op_done,
   output logic                      op_err,
   output logic [pq_pkg::DATA_W-1:0] head_key
);
   import pq_pkg::*;

   typedef enum logic [2:0] {
      IDLE,
      INS_RD,
      INS_WR,
      DEQ_HEAD,
      DEQ_RD,
      DEQ_WR,
      FINISH
   } state_e;

   state_e            state;
   // Occupancy, 0 to DEPTH
   logic [CNT_W-1:0]  count;
   // Address walker, reaches count on a full dequeue
   logic [CNT_W-1:0]  idx;
   // Key travelling down the array during an insert
   logic [DATA_W-1:0] carried;
   // Operation kind and reject flag for FINISH
   logic              deq_op;
   logic              rej;
   logic              at_tail;

   // Walker sits on the first free slot
   assign at_tail = (idx == count);

   ////////////////////
   // Status
   ////////////////////

   assign status.count = count;
   assign status.full  = (count == CNT_W'(DEPTH));
   assign status.empty = (count == '0);

   assign busy    = (state != IDLE);
   // FINISH ends every operation, accepted or rejected
   assign op_done = (state == FINISH) & ~rej;
   assign op_err  = (state == FINISH) & rej;

   ////////////////////
   // FSM
   ////////////////////

   always_ff @(posedge clk) begin
      if (rst) begin
         state  <= IDLE;
         count  <= '0;
         idx    <= '0;
         deq_op <= 1'b0;
         rej    <= 1'b0;
      end else begin
         case (state)
            IDLE: begin
               if (cmd_valid) begin
                  deq_op <= ~cmd.op_enq;
                  // Illegal for current count, one cycle in FINISH then err
                  if ((cmd.op_enq && status.full) || (cmd.op_deq && status.empty)) begin
                     rej   <= 1'b1;
                     state <= FINISH;
                  end else if (cmd.op_enq) begin
                     rej   <= 1'b0;
                     idx   <= '0;
                     state <= INS_RD;
                  end else begin
                     // Head read first, shifts start at address 1
                     rej   <= 1'b0;
                     idx   <= CNT_W'(1);
                     state <= DEQ_HEAD;
                  end
               end
            end
            INS_RD: state <= INS_WR;
            INS_WR: begin
               // Tail slot written last
               if (at_tail) begin
                  state <= FINISH;
               end else begin
                  idx   <= idx + 1'b1;
                  state <= INS_RD;
               end
            end
            DEQ_HEAD: state <= DEQ_RD;
            // Nothing left to move down once idx hits count
            DEQ_RD: state <= at_tail ? FINISH : DEQ_WR;
            DEQ_WR: begin
               idx   <= idx + 1'b1;
               state <= DEQ_RD;
            end
            FINISH: begin
               if (!rej) begin
                  count <= deq_op ? count - 1'b1 : count + 1'b1;
               end
               state <= IDLE;
            end
            default: state <= IDLE;
         endcase
      end
   end

   // Carried key and head key
   always_ff @(posedge clk) begin
      if (state == IDLE && cmd_valid && cmd.op_enq) begin
         carried <= cmd.key;
      end else if (state == INS_WR) begin
         // Displaced key moves on to the next address
         carried <= rsp.to_register;
      end
      // First DEQ_RD sees the address 0 read from DEQ_HEAD
      if (state == DEQ_RD && idx == CNT_W'(1)) begin
         head_key <= rdata;
      end
   end

   ////////////////////
   // BRAM and router drive
   ////////////////////

   always_comb begin
      addr         = idx[ADDR_W-1:0];
      we           = 1'b0;
      wdata        = rsp.bram_insert;
      req.mode     = ROUTE_IDLE;
      req.at_tail  = at_tail;
      req.carried  = carried;
      req.bram_key = rdata;
      case (state)
         DEQ_HEAD: addr = '0;
         INS_WR: begin
            req.mode = ROUTE_SWAP;
            // Skip the write when the stored key stays
            we       = rsp.swapped;
         end
         DEQ_WR: begin
            req.mode = ROUTE_SHIFT;
            // Key from idx lands one address lower
            addr     = ADDR_W'(idx - 1'b1);
            we       = 1'b1;
         end
         default: ;
      endcase
   end

endmodule

// ==== pq_cmd_capture.sv ====
module pq_cmd_capture (
   input  logic                      clk,
   input  logic                      rst,
   input  logic                      enq,
   input  logic                      deq,
   input  logic [pq_pkg::DATA_W-1:0] enq_data,
   input  logic                      busy,
   output logic                      cmd_valid,
   output pq_pkg::pq_cmd_t           cmd
);

   ////////////////////
   // Acceptance
   ////////////////////

   // High when a strobe is taken this cycle
   logic accept;

   // Any strobe counts, but only while the queue is idle
   // Also blocked in the cycle the last command is handed over,
   // since busy only rises one cycle after cmd_valid
   assign accept = (enq | deq) & ~busy & ~cmd_valid;

   ////////////////////
   // Command register
   ////////////////////

   // One-cycle valid pulse
   always_ff @(posedge clk) begin
      if (rst) begin
         cmd_valid <= 1'b0;
      end else begin
         cmd_valid <= accept;
      end
   end

   // Payload held until the next accepted strobe
   // Sequencer and output side may look at it during the whole operation
   always_ff @(posedge clk) begin
      if (accept) begin
         // Insert has priority
         cmd.op_enq <= enq;
         // Dequeue only when no insert at the same time
         cmd.op_deq <= deq & ~enq;
         // Key captured even on dequeue, ignored there
         cmd.key    <= enq_data;
      end
   end

endmodule

// ==== pq_pkg.sv ====
package pq_pkg;

   ////////////////////
   // Sizes
   ////////////////////

   // Key width
   localparam int DATA_W = 32;
   // Queue capacity in keys
   localparam int DEPTH = 16;
   // BRAM address width
   localparam int ADDR_W = $clog2(DEPTH);
   // One extra bit so the count can reach DEPTH
   localparam int CNT_W = ADDR_W + 1;

   ////////////////////
   // Types
   ////////////////////

   // Router operating mode
   typedef enum logic [1:0] {
      ROUTE_IDLE  = 2'd0,
      ROUTE_SWAP  = 2'd1,
      ROUTE_SHIFT = 2'd2
   } route_mode_e;

   // Captured command, insert wins over dequeue
   typedef struct packed {
      logic              op_enq;
      logic              op_deq;
      logic [DATA_W-1:0] key;
   } pq_cmd_t;

   // Sequencer to router
   typedef struct packed {
      route_mode_e       mode;
      logic              at_tail;
      logic [DATA_W-1:0] carried;
      logic [DATA_W-1:0] bram_key;
   } route_req_t;

   // Router back to sequencer
   typedef struct packed {
      logic [DATA_W-1:0] bram_insert;
      logic [DATA_W-1:0] to_register;
      logic              swapped;
   } route_rsp_t;

   // Queue status
   typedef struct packed {
      logic [CNT_W-1:0] count;
      logic             full;
      logic             empty;
   } pq_status_t;

endpackage
